// File: files.f
source/ldst_pkg.sv
source/ldst_address_unit.sv
source/load_data_aligner.sv
source/ldst_execute_port.sv
source/data_ram.sv
source/ldst_subsystem.sv
verification/ldst_assertions.sv
verification/ldst_tb.sv

// File: Bender.yml
package:
  name: ldst_subsystem

sources:
  - source/ldst_pkg.sv
  - source/ldst_address_unit.sv
  - source/load_data_aligner.sv
  - source/ldst_execute_port.sv
  - source/data_ram.sv
  - source/ldst_subsystem.sv
  - target: test
    files:
      - verification/ldst_assertions.sv
      - verification/ldst_tb.sv

// File: verification/ldst_tb.sv
module ldst_tb;

	localparam int CLK_PERIOD = 8;
	localparam int RESET_CYCLES = 10;
	localparam int RANDOM_OPS = 400;
	localparam int DIRECTED_OPS = 40;
	localparam int STALL_PCT = 30;
	// Minimum of 3 cycles, a generous stall run and an idle gap
	localparam int CYCLES_PER_OP = 3 + 10 + 1;
	localparam int TOTAL_OPS = ldst_pkg::RAM_WORDS + DIRECTED_OPS + RANDOM_OPS;
	localparam longint TIMEOUT =
		longint'(TOTAL_OPS * CYCLES_PER_OP + RESET_CYCLES + 200) * CLK_PERIOD;

	logic iCLOCK;
	logic inRESET;
	logic mem_stall;
	logic issue_valid;
	ldst_pkg::issue_req_t issue;
	logic issue_lock;
	logic complete_valid;
	ldst_pkg::complete_t complete;

	// Reference copy of the RAM and the SPR
	ldst_pkg::data_t model_mem [ldst_pkg::RAM_WORDS];
	ldst_pkg::data_t model_spr;
	ldst_pkg::complete_t expected_q[$];

	int issued;
	int completions;
	int errors;

	ldst_subsystem ldst_subsystem_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.mem_stall(mem_stall),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_lock(issue_lock),
		.complete_valid(complete_valid),
		.complete(complete)
	);

	initial begin
		iCLOCK = 1'b0;
		forever begin
			#(CLK_PERIOD / 2) iCLOCK = ~iCLOCK;
		end
	end

	task automatic compare_complete(input ldst_pkg::complete_t got,
		input ldst_pkg::complete_t exp);
		logic match;
		// Data only counts when writeback is set
		match = (got.tag === exp.tag) && (got.dest === exp.dest) &&
			(got.writeback === exp.writeback) && (!exp.writeback || got.data === exp.data);
		if (!match) begin
			errors++;
			$display("[ERROR] %0t: completion tag %0d dest %0d wb %0b data %h", $time,
				got.tag, got.dest, got.writeback, got.data);
			$display("[ERROR] %0t: expected   tag %0d dest %0d wb %0b data %h", $time,
				exp.tag, exp.dest, exp.writeback, exp.data);
		end
	endtask

	task automatic compare_count(input int got, input int exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic compare_flag(input logic got, input logic exp, input string what);
		if (got !== exp) begin
			errors++;
			$display("[ERROR] %0t: %s is %b, expected %b", $time, what, got, exp);
		end
	endtask

	function automatic int word_index(input ldst_pkg::data_t addr);
		return int'((addr >> 2) % ldst_pkg::RAM_WORDS);
	endfunction

	// Initial memory contents, distinct per word
	function automatic ldst_pkg::data_t fill_word(input int i);
		logic [7:0] k;
		k = 8'(i);
		return {k ^ 8'h5a, ~k, k + 8'h33, k};
	endfunction

	task automatic apply_model(input ldst_pkg::issue_req_t op);
		ldst_pkg::complete_t exp;
		ldst_pkg::data_t addr;
		ldst_pkg::data_t word;
		logic [7:0] b;
		logic [15:0] h;
		int idx;
		addr = op.src0 + op.src1;
		if (op.cmd == ldst_pkg::PUSH) begin
			model_spr = model_spr - 32'd4;
			addr = model_spr;
		end else if (op.cmd == ldst_pkg::POP) begin
			addr = model_spr;
			model_spr = model_spr + 32'd4;
		end
		idx = word_index(addr);
		word = model_mem[idx];
		b = 8'(word >> (8 * addr[1:0]));
		h = addr[1] ? word[31:16] : word[15:0];
		exp.tag = op.tag;
		exp.dest = op.dest;
		exp.writeback = 1'b1;
		exp.data = word;
		case (op.cmd)
			ldst_pkg::LD8U: exp.data = {24'h0, b};
			ldst_pkg::LD8S: exp.data = {{24{b[7]}}, b};
			ldst_pkg::LD16U: exp.data = {16'h0, h};
			ldst_pkg::LD16S: exp.data = {{16{h[15]}}, h};
			ldst_pkg::ST8: begin
				model_mem[idx][8 * addr[1:0] +: 8] = op.src0[7:0];
				exp.writeback = 1'b0;
			end
			ldst_pkg::ST16: begin
				if (addr[1]) begin
					model_mem[idx][31:16] = op.src0[15:0];
				end else begin
					model_mem[idx][15:0] = op.src0[15:0];
				end
				exp.writeback = 1'b0;
			end
			ldst_pkg::ST32, ldst_pkg::PUSH: begin
				model_mem[idx] = op.src0;
				exp.writeback = 1'b0;
			end
			ldst_pkg::WRITE_SPR: begin
				model_spr = op.src0;
				exp.writeback = 1'b0;
			end
			ldst_pkg::READ_SPR: exp.data = model_spr;
			ldst_pkg::ADD_SPR: begin
				model_spr = model_spr + op.src1;
				exp.data = model_spr;
			end
			default: exp.data = word;
		endcase
		expected_q.push_back(exp);
	endtask

	task automatic next_cycle();
		@(negedge iCLOCK);
		mem_stall = ($urandom_range(99) < STALL_PCT);
	endtask

	// Hold the operation until the port takes it
	task automatic issue_op(input ldst_pkg::ldst_cmd_e cmd, input ldst_pkg::data_t src0,
		input ldst_pkg::data_t src1);
		logic taken;
		issue.cmd = cmd;
		issue.tag = ldst_pkg::tag_t'(issued);
		issue.dest = ldst_pkg::preg_t'($urandom);
		issue.src0 = src0;
		issue.src1 = src1;
		issue_valid = 1'b1;
		taken = 1'b0;
		while (!taken) begin
			#1;
			if (mem_stall) begin
				compare_flag(issue_lock, 1'b1, "issue_lock under stall");
			end
			taken = !issue_lock;
			if (taken) begin
				apply_model(issue);
				issued++;
			end
			next_cycle();
		end
		issue_valid = 1'b0;
		if ($urandom_range(3) == 0) begin
			next_cycle();
		end
	endtask

	task automatic issue_at(input ldst_pkg::ldst_cmd_e cmd, input ldst_pkg::data_t src0,
		input ldst_pkg::data_t addr);
		issue_op(cmd, src0, addr - src0);
	endtask

	// Completion monitor
	initial begin
		forever begin
			@(negedge iCLOCK);
			if (inRESET && complete_valid) begin
				completions++;
				if (expected_q.size() == 0) begin
					errors++;
					$display("Completion with tag %0d arrived with nothing outstanding",
						complete.tag);
				end else begin
					compare_complete(complete, expected_q.pop_front());
				end
			end
		end
	end

	initial begin
		#(TIMEOUT);
		$display("Timeout: only %0d of %0d operations completed", completions, issued);
		$display("FAIL: see errors above");
		$finish;
	end

	initial begin
		ldst_pkg::data_t base;
		ldst_pkg::ldst_cmd_e cmd;
		ldst_pkg::data_t addr;
		int assert_failures;
		void'($urandom(32'hde83_6b22));
		inRESET = 1'b0;
		issue_valid = 1'b0;
		issue = '0;
		mem_stall = 1'b0;
		issued = 0;
		completions = 0;
		errors = 0;
		model_spr = '0;
		repeat (RESET_CYCLES) @(negedge iCLOCK);
		compare_flag(issue_lock, 1'b0, "issue_lock in reset");
		compare_flag(complete_valid, 1'b0, "complete_valid in reset");
		inRESET = 1'b1;

		// Every word gets a known value before any load
		for (int i = 0; i < ldst_pkg::RAM_WORDS; i++) begin
			model_mem[i] = 'x;
			issue_at(ldst_pkg::ST32, fill_word(i), ldst_pkg::data_t'(4 * i));
		end

		// Lane rules for each store and load width
		base = 32'h0000_0140;
		issue_at(ldst_pkg::ST32, 32'h8899_aabb, base);
		issue_at(ldst_pkg::ST8, 32'h1234_56c3, base + 1);
		issue_at(ldst_pkg::ST16, 32'hcafe_9e71, base + 3);
		for (int lane = 0; lane < 4; lane++) begin
			issue_at(ldst_pkg::LD8U, $urandom, base + lane);
			issue_at(ldst_pkg::LD8S, $urandom, base + lane);
			issue_at(ldst_pkg::LD16U, $urandom, base + lane);
			issue_at(ldst_pkg::LD16S, $urandom, base + lane);
		end
		issue_at(ldst_pkg::LD32, $urandom, base);

		// Stack pointer commands, push and pop
		issue_op(ldst_pkg::WRITE_SPR, 32'h0000_0200, $urandom);
		issue_op(ldst_pkg::READ_SPR, $urandom, $urandom);
		issue_op(ldst_pkg::PUSH, 32'h5eed_f00d, $urandom);
		issue_op(ldst_pkg::READ_SPR, $urandom, $urandom);
		issue_op(ldst_pkg::POP, $urandom, $urandom);
		issue_op(ldst_pkg::READ_SPR, $urandom, $urandom);
		issue_op(ldst_pkg::ADD_SPR, $urandom, 32'hffff_fff0);
		issue_op(ldst_pkg::READ_SPR, $urandom, $urandom);

		for (int n = 0; n < RANDOM_OPS; n++) begin
			cmd = ldst_pkg::ldst_cmd_e'($urandom_range(12));
			addr = $urandom_range(4 * ldst_pkg::RAM_WORDS - 1);
			issue_at(cmd, $urandom, addr);
		end

		// Drain with the memory free
		mem_stall = 1'b0;
		while (completions < issued) begin
			@(posedge iCLOCK);
		end
		repeat (4) @(posedge iCLOCK);
		compare_count(completions, issued, "completion count");
		compare_count(expected_q.size(), 0, "outstanding completions");
		assert_failures =
			ldst_subsystem_inst.ldst_execute_port_inst.ldst_assertions_inst.failures;
		$display("Summary: %0d issued, %0d completed, %0d check errors, %0d assertion failures",
			issued, completions, errors, assert_failures);
		if (errors == 0 && assert_failures == 0) begin
			$display("PASS: all tests");
		end else begin
			$display("FAIL: see errors above");
		end
		$finish;
	end

endmodule

// File: verification/ldst_assertions.sv
module ldst_assertions (
	input logic iCLOCK,
	input logic inRESET,
	input logic issue_valid,
	input ldst_pkg::issue_req_t issue,
	input logic issue_lock,
	input logic mem_req_valid,
	input logic mem_resp_valid
);

	int failures = 0;

	// Issuer keeps its operation steady while locked out
	hold_while_locked: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		issue_valid && issue_lock |=> issue_valid && $stable(issue))
		else begin
			failures++;
			$error("issuer dropped or changed its operation while locked");
		end

	// Response follows each request after one cycle
	resp_after_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_req_valid |=> mem_resp_valid)
		else begin
			failures++;
			$error("no response one cycle after a request");
		end

	// No response without a request just before
	resp_needs_req: assert property (@(posedge iCLOCK) disable iff (!inRESET)
		mem_resp_valid |-> $past(mem_req_valid))
		else begin
			failures++;
			$error("response without a request in the previous cycle");
		end

endmodule

bind ldst_execute_port ldst_assertions ldst_assertions_inst (
	.iCLOCK(iCLOCK),
	.inRESET(inRESET),
	.issue_valid(issue_valid),
	.issue(issue),
	.issue_lock(issue_lock),
	.mem_req_valid(mem_req_valid),
	.mem_resp_valid(mem_resp_valid)
);

// File: source/ldst_subsystem.sv
module ldst_subsystem (
	input logic iCLOCK,
	input logic inRESET,
	input logic mem_stall,
	input logic issue_valid,
	input ldst_pkg::issue_req_t issue,
	output logic issue_lock,
	output logic complete_valid,
	output ldst_pkg::complete_t complete
);

	logic mem_req_valid;
	ldst_pkg::mem_req_t mem_req;
	logic mem_busy;
	logic mem_resp_valid;
	ldst_pkg::data_t mem_rdata;

	ldst_execute_port ldst_execute_port_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.issue_valid(issue_valid),
		.issue(issue),
		.issue_lock(issue_lock),
		.mem_req_valid(mem_req_valid),
		.mem_req(mem_req),
		.mem_busy(mem_busy),
		.mem_resp_valid(mem_resp_valid),
		.mem_rdata(mem_rdata),
		.complete_valid(complete_valid),
		.complete(complete)
	);

	data_ram data_ram_inst (
		.iCLOCK(iCLOCK),
		.inRESET(inRESET),
		.stall(mem_stall),
		.busy(mem_busy),
		.req_valid(mem_req_valid),
		.req(mem_req),
		.resp_valid(mem_resp_valid),
		.rdata(mem_rdata)
	);

endmodule

// File: source/data_ram.sv
module data_ram (
	input logic iCLOCK,
	input logic inRESET,
	input logic stall,
	output logic busy,
	input logic req_valid,
	input ldst_pkg::mem_req_t req,
	output logic resp_valid,
	output ldst_pkg::data_t rdata
);

	ldst_pkg::data_t mem [ldst_pkg::RAM_WORDS];
	logic [ldst_pkg::RAM_INDEX_W-1:0] index;

	// Word index, upper address bits dropped
	assign index = req.addr[ldst_pkg::RAM_INDEX_W+1:2];

	// Contention from other masters
	assign busy = stall;

	always_ff @(posedge iCLOCK) begin
		if (req_valid) begin
			if (req.write) begin
				for (int i = 0; i < 4; i++) begin
					if (req.mask[i]) begin
						mem[index][8*i +: 8] <= req.wdata[8*i +: 8];
					end
				end
			end
			rdata <= mem[index];
		end
	end

	// Response one cycle after every request
	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= req_valid;
		end
	end

endmodule

// File: source/ldst_execute_port.sv
module ldst_execute_port (
	input logic iCLOCK,
	input logic inRESET,
	input logic issue_valid,
	input ldst_pkg::issue_req_t issue,
	output logic issue_lock,
	output logic mem_req_valid,
	output ldst_pkg::mem_req_t mem_req,
	input logic mem_busy,
	input logic mem_resp_valid,
	input ldst_pkg::data_t mem_rdata,
	output logic complete_valid,
	output ldst_pkg::complete_t complete
);

	ldst_pkg::ldst_state_e state;
	ldst_pkg::data_t spr;
	logic spr_done;
	logic accept;

	ldst_pkg::mem_req_t addr_req;
	logic is_mem;
	logic spr_we;
	ldst_pkg::data_t spr_next;

	// Operation latched at acceptance
	ldst_pkg::mem_req_t req_q;
	ldst_pkg::ldst_cmd_e cmd_q;
	ldst_pkg::tag_t tag_q;
	ldst_pkg::preg_t dest_q;

	ldst_pkg::data_t load_data;
	logic mem_done;

	// Busy memory also holds off the issuer
	assign issue_lock = (state != ldst_pkg::IDLE) || mem_busy;
	assign accept = issue_valid && !issue_lock;

	ldst_address_unit ldst_address_unit_inst (
		.cmd(issue.cmd),
		.src0(issue.src0),
		.src1(issue.src1),
		.spr(spr),
		.req(addr_req),
		.is_mem(is_mem),
		.spr_we(spr_we),
		.spr_next(spr_next)
	);

	always_ff @(posedge iCLOCK or negedge inRESET) begin
		if (!inRESET) begin
			state <= ldst_pkg::IDLE;
			spr <= '0;
			spr_done <= 1'b0;
		end else begin
			// SPR-only commands finish one cycle after accept
			spr_done <= accept && !is_mem;
			if (accept && spr_we) begin
				spr <= spr_next;
			end
			case (state)
				ldst_pkg::IDLE: begin
					if (accept && is_mem) begin
						state <= addr_req.write ? ldst_pkg::STREQ : ldst_pkg::LDREQ;
					end
				end
				ldst_pkg::LDREQ: begin
					if (!mem_busy) begin
						state <= ldst_pkg::LDWAIT;
					end
				end
				ldst_pkg::LDWAIT: begin
					if (mem_resp_valid) begin
						state <= ldst_pkg::IDLE;
					end
				end
				ldst_pkg::STREQ: begin
					if (!mem_busy) begin
						state <= ldst_pkg::STWAIT;
					end
				end
				ldst_pkg::STWAIT: begin
					if (mem_resp_valid) begin
						state <= ldst_pkg::IDLE;
					end
				end
				default: begin
					state <= ldst_pkg::IDLE;
				end
			endcase
		end
	end

	always_ff @(posedge iCLOCK) begin
		if (accept) begin
			req_q <= addr_req;
			cmd_q <= issue.cmd;
			tag_q <= issue.tag;
			dest_q <= issue.dest;
		end
	end

	// Request only from a REQ state with the memory free
	assign mem_req_valid = ((state == ldst_pkg::LDREQ) || (state == ldst_pkg::STREQ)) &&
		!mem_busy;
	assign mem_req = req_q;

	load_data_aligner load_data_aligner_inst (
		.cmd(cmd_q),
		.lane(req_q.addr[1:0]),
		.rdata(mem_rdata),
		.data(load_data)
	);

	assign mem_done = ((state == ldst_pkg::LDWAIT) || (state == ldst_pkg::STWAIT)) &&
		mem_resp_valid;
	assign complete_valid = mem_done || spr_done;

	always_comb begin
		complete.tag = tag_q;
		complete.dest = dest_q;
		// SPR already holds the updated value here
		complete.data = spr_done ? spr : load_data;
		case (cmd_q)
			ldst_pkg::LD8U, ldst_pkg::LD8S, ldst_pkg::LD16U, ldst_pkg::LD16S,
			ldst_pkg::LD32, ldst_pkg::POP, ldst_pkg::READ_SPR, ldst_pkg::ADD_SPR: begin
				complete.writeback = 1'b1;
			end
			default: begin
				complete.writeback = 1'b0;
			end
		endcase
	end

endmodule

// File: source/load_data_aligner.sv
module load_data_aligner (
	input ldst_pkg::ldst_cmd_e cmd,
	input logic [1:0] lane,
	input ldst_pkg::data_t rdata,
	output ldst_pkg::data_t data
);

	logic [7:0] byte_sel;
	logic [15:0] half_sel;

	// Addressed byte, and halfword picked by lane bit 1 only
	assign byte_sel = rdata[{lane, 3'b000} +: 8];
	assign half_sel = lane[1] ? rdata[31:16] : rdata[15:0];

	always_comb begin
		case (cmd)
			ldst_pkg::LD8U: begin
				data = {24'h0, byte_sel};
			end
			ldst_pkg::LD8S: begin
				data = {{24{byte_sel[7]}}, byte_sel};
			end
			ldst_pkg::LD16U: begin
				data = {16'h0, half_sel};
			end
			ldst_pkg::LD16S: begin
				data = {{16{half_sel[15]}}, half_sel};
			end
			// Whole word for LD32 and POP
			default: begin
				data = rdata;
			end
		endcase
	end

endmodule

// File: source/ldst_address_unit.sv
module ldst_address_unit (
	input ldst_pkg::ldst_cmd_e cmd,
	input ldst_pkg::data_t src0,
	input ldst_pkg::data_t src1,
	input ldst_pkg::data_t spr,
	output ldst_pkg::mem_req_t req,
	output logic is_mem,
	output logic spr_we,
	output ldst_pkg::data_t spr_next
);

	ldst_pkg::data_t ea;
	ldst_pkg::lane_mask_t byte_mask;
	ldst_pkg::lane_mask_t half_mask;

	// Effective address for plain loads and stores
	assign ea = src0 + src1;

	// Lane selects from the low address bits
	assign byte_mask = 4'b0001 << ea[1:0];
	assign half_mask = ea[1] ? 4'b1100 : 4'b0011;

	always_comb begin
		req.write = 1'b0;
		req.addr = ea;
		req.mask = 4'hf;
		req.wdata = src0;
		is_mem = 1'b1;
		spr_we = 1'b0;
		spr_next = spr;
		case (cmd)
			ldst_pkg::LD8U, ldst_pkg::LD8S: begin
				req.mask = byte_mask;
			end
			ldst_pkg::LD16U, ldst_pkg::LD16S: begin
				req.mask = half_mask;
			end
			ldst_pkg::LD32: begin
				req.mask = 4'hf;
			end
			// Sub-word stores replicate data over all lanes
			ldst_pkg::ST8: begin
				req.write = 1'b1;
				req.mask = byte_mask;
				req.wdata = {4{src0[7:0]}};
			end
			ldst_pkg::ST16: begin
				req.write = 1'b1;
				req.mask = half_mask;
				req.wdata = {2{src0[15:0]}};
			end
			ldst_pkg::ST32: begin
				req.write = 1'b1;
			end
			// Pre-decrement push
			ldst_pkg::PUSH: begin
				req.write = 1'b1;
				req.addr = spr - ldst_pkg::SPR_STEP;
				spr_we = 1'b1;
				spr_next = spr - ldst_pkg::SPR_STEP;
			end
			// Post-increment pop
			ldst_pkg::POP: begin
				req.addr = spr;
				spr_we = 1'b1;
				spr_next = spr + ldst_pkg::SPR_STEP;
			end
			ldst_pkg::WRITE_SPR: begin
				is_mem = 1'b0;
				spr_we = 1'b1;
				spr_next = src0;
			end
			ldst_pkg::ADD_SPR: begin
				is_mem = 1'b0;
				spr_we = 1'b1;
				spr_next = spr + src1;
			end
			default: begin
				is_mem = 1'b0;
			end
		endcase
	end

endmodule

// File: source/ldst_pkg.sv
package ldst_pkg;

	// Meaningful widths
	typedef logic [31:0] data_t;
	typedef logic [5:0] tag_t;
	typedef logic [5:0] preg_t;
	typedef logic [3:0] lane_mask_t;

	// Data memory depth in words
	localparam int RAM_WORDS = 256;
	localparam int RAM_INDEX_W = $clog2(RAM_WORDS);

	// Stack grows downward by one word
	localparam data_t SPR_STEP = 32'd4;

	typedef enum logic [4:0] {
		LD8U = 5'h00,
		LD8S = 5'h01,
		LD16U = 5'h02,
		LD16S = 5'h03,
		LD32 = 5'h04,
		ST8 = 5'h05,
		ST16 = 5'h06,
		ST32 = 5'h07,
		PUSH = 5'h08,
		POP = 5'h09,
		WRITE_SPR = 5'h0a,
		READ_SPR = 5'h0b,
		ADD_SPR = 5'h0c
	} ldst_cmd_e;

	typedef enum logic [2:0] {
		IDLE = 3'h0,
		LDREQ = 3'h1,
		LDWAIT = 3'h2,
		STREQ = 3'h3,
		STWAIT = 3'h4
	} ldst_state_e;

	// Operation offered by the issue stage
	typedef struct packed {
		ldst_cmd_e cmd;
		tag_t tag;
		preg_t dest;
		data_t src0;
		data_t src1;
	} issue_req_t;

	// Request toward the data memory
	typedef struct packed {
		logic write;
		data_t addr;
		lane_mask_t mask;
		data_t wdata;
	} mem_req_t;

	// Completion record for the scheduler
	typedef struct packed {
		tag_t tag;
		preg_t dest;
		logic writeback;
		data_t data;
	} complete_t;

endpackage
